// File: hdl/audio_pkg.sv
// shared widths, register map and constants of the three-voice audio block
// the register index is iomem_addr[5:2]; voice v owns words 4v to 4v+3
// bit positions refer to the wave word of each voice
package audio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////
  // one voice sample, signed
  localparam int sample_bits = 12;
  // mix and pdm input, two bits of headroom over a sample
  localparam int mix_bits = 14;
  // phase accumulator and frequency word
  localparam int acc_bits = 24;
  localparam int pw_bits = 12;
  localparam int lfsr_bits = 23;

  // noise generator start pattern, also forced while test is held
  localparam logic [lfsr_bits-1:0] lfsr_seed = 23'b01101110010010000101011;

  // clocks per accumulator tick
  localparam int tick_div = 16;

  localparam int num_voices = 3;
  localparam int voice_regs = 4;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////
  // low two bits select the word inside a voice, status sits above the voices
  typedef enum logic [3:0] {
    reg_freq   = 4'd0,
    reg_pulse  = 4'd1,
    reg_wave   = 4'd2,
    reg_gate   = 4'd3,
    reg_status = 4'd14
  } reg_addr_e;

  // wave word fields
  localparam int wave_tri = 16;
  localparam int wave_saw = 17;
  localparam int wave_pulse = 18;
  localparam int wave_noise = 19;
  // triangle inversion taken from the neighbour msb
  localparam int ring_en = 24;
  // holds accumulator at zero and lfsr at seed
  localparam int test_bit = 25;
  localparam int voice_en = 27;
  // hard sync to the neighbour
  localparam int sync_en = 28;

endpackage

// File: hdl/audio_regs.sv
// configuration words for three voices, written over the iomem strobe
// ready answers one cycle after valid; a held valid gets one transfer per 2 clocks
// words 12, 13 and 15 read zero, word 14 is read-only status
`timescale 1ns/1ns

module audio_regs (
  input  logic        clk,
  input  logic        resetn,
  input  logic        iomem_valid,
  input  logic [3:0]  iomem_wstrb,
  input  logic [31:0] iomem_addr,
  input  logic [31:0] iomem_wdata,
  input  logic [2:0]  sync_bits,
  input  logic [2:0]  msb_bits,
  output logic        iomem_ready,
  output logic [31:0] iomem_rdata,
  output logic        tick,
  output logic [audio_pkg::acc_bits-1:0] freq [audio_pkg::num_voices],
  output logic [audio_pkg::pw_bits-1:0]  pulse_width [audio_pkg::num_voices],
  output logic [31:0] wave [audio_pkg::num_voices],
  output logic [2:0]  gate
);

  localparam int num_words = audio_pkg::num_voices * audio_pkg::voice_regs;
  localparam int cnt_bits = $clog2(audio_pkg::tick_div);

  logic [31:0] voice_word [num_words];
  logic [3:0]  word_sel;
  logic [31:0] rd_word;
  logic        bus_hit;
  logic [cnt_bits-1:0] tick_cnt;

  assign word_sel = iomem_addr[5:2];
  // new request only while ready is low
  assign bus_hit = iomem_valid && !iomem_ready;

  ////////////////////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////////////////////
  // read mux, status assembled from live voice flags
  always_comb begin
    rd_word = '0;
    if (word_sel < num_words) begin
      rd_word = voice_word[word_sel];
    end else if (word_sel == 4'(audio_pkg::reg_status)) begin
      rd_word = {21'd0, msb_bits, 5'd0, sync_bits};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      iomem_ready <= 1'b0;
      for (int w = 0; w < num_words; w++) begin
        voice_word[w] <= '0;
      end
    end else begin
      iomem_ready <= bus_hit;
      // byte lanes, only the voice words take writes
      if (bus_hit && word_sel < num_words) begin
        for (int b = 0; b < 4; b++) begin
          if (iomem_wstrb[b]) begin
            voice_word[word_sel][8*b +: 8] <= iomem_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read data returns the word as it was before this write
  always_ff @(posedge clk) begin
    if (bus_hit) begin
      iomem_rdata <= rd_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulator tick, high for one clock after every 16th edge
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tick_cnt <= '0;
      tick <= 1'b0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick <= (tick_cnt == cnt_bits'(audio_pkg::tick_div - 1));
    end
  end

  // per voice fields
  for (genvar v = 0; v < audio_pkg::num_voices; v++) begin : g_fields
    localparam int base = v * audio_pkg::voice_regs;
    assign freq[v] = voice_word[base + audio_pkg::reg_freq][audio_pkg::acc_bits-1:0];
    assign pulse_width[v] = voice_word[base + audio_pkg::reg_pulse][audio_pkg::pw_bits-1:0];
    assign wave[v] = voice_word[base + audio_pkg::reg_wave];
    assign gate[v] = voice_word[base + audio_pkg::reg_gate][0];
  end

endmodule

// File: hdl/audio_voice.sv
// one oscillator voice; accumulator and lfsr advance only on tick
// the sample is combinational from that state and the current wave word
// no envelope, gate switches between full and zero amplitude
`timescale 1ns/1ns

module audio_voice (
  input  logic clk,
  input  logic resetn,
  input  logic tick,
  input  logic [audio_pkg::acc_bits-1:0] freq,
  input  logic [audio_pkg::pw_bits-1:0]  pulse_width,
  input  logic [31:0] wave,
  input  logic gate,
  // neighbour sync pulse and msb
  input  logic sync_in,
  input  logic ring_in,
  output logic signed [audio_pkg::sample_bits-1:0] sample,
  output logic sync_out,
  output logic msb_out
);

  localparam int sb = audio_pkg::sample_bits;
  localparam int ab = audio_pkg::acc_bits;
  localparam logic [sb-1:0] full_scale = '1;

  logic [ab-1:0] acc;
  logic [ab-1:0] acc_next;
  logic [audio_pkg::lfsr_bits-1:0] lfsr;

  logic test;
  logic tri_inv;
  logic [sb-1:0] tri_wave;
  logic [sb-1:0] saw_wave;
  logic [sb-1:0] pulse_wave;
  logic [sb-1:0] noise_wave;
  logic [sb-1:0] mixed;
  logic signed [sb-1:0] signed_wave;
  logic signed [8:0] amp;
  logic signed [sb+7:0] product;
  logic signed [sb+7:0] scaled;

  assign test = wave[audio_pkg::test_bit];
  assign msb_out = acc[ab-1];

  ////////////////////////////////////////////////////////////////////////////
  // phase accumulator and noise
  ////////////////////////////////////////////////////////////////////////////
  // test and hard sync both park the phase at zero
  always_comb begin
    if (test || (wave[audio_pkg::sync_en] && sync_in)) begin
      acc_next = '0;
    end else begin
      acc_next = acc + freq;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc <= '0;
      sync_out <= 1'b0;
    end else if (tick) begin
      acc <= acc_next;
      // msb rising edge, held until the next tick
      sync_out <= !acc[ab-1] && acc_next[ab-1];
    end
  end

  // lfsr clocked by accumulator bit 19, seed forced every clock under test
  always_ff @(posedge clk) begin
    if (!resetn || test) begin
      lfsr <= audio_pkg::lfsr_seed;
    end else if (tick && acc[19]) begin
      lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // wave shaping
  ////////////////////////////////////////////////////////////////////////////
  // ring mod swaps the fold point to the neighbour msb
  assign tri_inv = wave[audio_pkg::ring_en] ? ring_in : acc[ab-1];
  assign tri_wave = tri_inv ? ~acc[ab-2 -: sb] : acc[ab-2 -: sb];
  assign saw_wave = acc[ab-1 -: sb];
  assign pulse_wave = (acc[ab-1 -: audio_pkg::pw_bits] <= pulse_width) ? full_scale : '0;
  // eight taps spread over the register, low nibble zero
  assign noise_wave = {lfsr[22], lfsr[20], lfsr[16], lfsr[13],
                       lfsr[11], lfsr[7], lfsr[4], lfsr[2], 4'b0000};

  always_comb begin
    // unselected waves count as all ones in the and
    mixed = full_scale;
    if (wave[audio_pkg::wave_tri]) begin
      mixed = mixed & tri_wave;
    end
    if (wave[audio_pkg::wave_saw]) begin
      mixed = mixed & saw_wave;
    end
    if (wave[audio_pkg::wave_pulse]) begin
      mixed = mixed & pulse_wave;
    end
    if (wave[audio_pkg::wave_noise]) begin
      mixed = mixed & noise_wave;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // gating and output
  ////////////////////////////////////////////////////////////////////////////
  // offset binary to two's complement
  assign signed_wave = {~mixed[sb-1], mixed[sb-2:0]};
  assign amp = gate ? 9'sd255 : 9'sd0;
  assign product = signed_wave * amp;
  // full scale lands on 2039 and -2040
  assign scaled = product >>> 8;
  assign sample = wave[audio_pkg::voice_en] ? scaled[sb-1:0] : '0;

endmodule

// File: hdl/audio_mixer.sv
// sums the voice samples, halves the sum and drives a first order pdm
// density of audio_out is (mix + 8192) / 16384
`timescale 1ns/1ns

module audio_mixer (
  input  logic clk,
  input  logic resetn,
  input  logic signed [audio_pkg::sample_bits-1:0] samples [audio_pkg::num_voices],
  output logic audio_out
);

  localparam int mb = audio_pkg::mix_bits;

  logic signed [mb-1:0] sum;
  logic signed [mb-1:0] mix;
  logic [mb-1:0] offset;
  logic [mb:0] pdm_acc;

  ////////////////////////////////////////////////////////////////////////////
  // mix
  ////////////////////////////////////////////////////////////////////////////
  // sign extend each sample, three full scale voices still fit 14 bits
  always_comb begin
    sum = '0;
    for (int v = 0; v < audio_pkg::num_voices; v++) begin
      sum = sum + mb'(samples[v]);
    end
  end

  // one clock behind any sample change
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mix <= '0;
    end else begin
      mix <= sum >>> 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pdm dac
  ////////////////////////////////////////////////////////////////////////////
  // msb flip gives offset binary
  assign offset = {~mix[mb-1], mix[mb-2:0]};

  // carry out of the low bits is the output pulse
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pdm_acc <= '0;
    end else begin
      pdm_acc <= {1'b0, pdm_acc[mb-1:0]} + {1'b0, offset};
    end
  end

  assign audio_out = pdm_acc[mb];

endmodule

// File: hdl/audio_top.sv
// audio peripheral top, register bank plus three parallel voices and the mixer
// voice v syncs and ring modulates from voice (v+2) mod 3
// audio_out is a one bit pdm stream that needs an external low pass filter
`timescale 1ns/1ns

module audio_top (
  input  logic        clk,
  input  logic        resetn,
  input  logic        iomem_valid,
  input  logic [3:0]  iomem_wstrb,
  input  logic [31:0] iomem_addr,
  input  logic [31:0] iomem_wdata,
  output logic        iomem_ready,
  output logic [31:0] iomem_rdata,
  output logic        audio_out
);

  localparam int nv = audio_pkg::num_voices;

  logic tick;
  logic [audio_pkg::acc_bits-1:0] freq [nv];
  logic [audio_pkg::pw_bits-1:0]  pulse_width [nv];
  logic [31:0] wave [nv];
  logic [2:0]  gate;
  logic [2:0]  sync_bits;
  logic [2:0]  msb_bits;
  logic signed [audio_pkg::sample_bits-1:0] samples [nv];

  audio_regs u_regs (
    .clk         (clk),
    .resetn      (resetn),
    .iomem_valid (iomem_valid),
    .iomem_wstrb (iomem_wstrb),
    .iomem_addr  (iomem_addr),
    .iomem_wdata (iomem_wdata),
    .sync_bits   (sync_bits),
    .msb_bits    (msb_bits),
    .iomem_ready (iomem_ready),
    .iomem_rdata (iomem_rdata),
    .tick        (tick),
    .freq        (freq),
    .pulse_width (pulse_width),
    .wave        (wave),
    .gate        (gate)
  );

  ////////////////////////////////////////////////////////////////////////////
  // voices, each fed by its predecessor in the ring
  ////////////////////////////////////////////////////////////////////////////
  for (genvar v = 0; v < nv; v++) begin : g_voice
    audio_voice u_voice (
      .clk         (clk),
      .resetn      (resetn),
      .tick        (tick),
      .freq        (freq[v]),
      .pulse_width (pulse_width[v]),
      .wave        (wave[v]),
      .gate        (gate[v]),
      .sync_in     (sync_bits[(v + 2) % nv]),
      .ring_in     (msb_bits[(v + 2) % nv]),
      .sample      (samples[v]),
      .sync_out    (sync_bits[v]),
      .msb_out     (msb_bits[v])
    );
  end

  audio_mixer u_mixer (
    .clk       (clk),
    .resetn    (resetn),
    .samples   (samples),
    .audio_out (audio_out)
  );

endmodule

// File: tests/tb_clock_gen.sv
// clock and reset source for the audio testbench
// 8 ns period, resetn held low for 3 rising edges and released on a falling edge
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  localparam int half_period = 4;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release away from the active edge
  initial begin
    resetn = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
  end

endmodule

// File: tests/audio_tb.sv
// testbench for audio_top; all inputs change on the falling edge
// level tests use parked phases or phase independent waves, so a model sample is constant
// density is counted over 16384 clocks and allowed to be off by one
`timescale 1ns/1ns

module audio_tb;

  localparam int wait_limit = 100;
  localparam int count_len = 16384;
  localparam int settle_clks = 40;
  localparam logic [31:0] saw_m = 32'(1) << audio_pkg::wave_saw;
  localparam logic [31:0] pulse_m = 32'(1) << audio_pkg::wave_pulse;
  localparam logic [31:0] noise_m = 32'(1) << audio_pkg::wave_noise;
  localparam logic [31:0] test_m = 32'(1) << audio_pkg::test_bit;
  localparam logic [31:0] en_m = 32'(1) << audio_pkg::voice_en;

  logic        clk;
  logic        resetn;
  logic        iomem_valid;
  logic [3:0]  iomem_wstrb;
  logic [31:0] iomem_addr;
  logic [31:0] iomem_wdata;
  logic        iomem_ready;
  logic [31:0] iomem_rdata;
  logic        audio_out;

  int errors;
  int checks;
  int tests;
  int test_start;
  // what the testbench last wrote to each voice
  logic [31:0] cfg_wave [3];
  logic        cfg_gate [3];
  logic [11:0] cfg_pw [3];
  logic [31:0] shadow [12];

  tb_clock_gen u_clk (.clk(clk), .resetn(resetn));

  audio_top uut (
    .clk         (clk),
    .resetn      (resetn),
    .iomem_valid (iomem_valid),
    .iomem_wstrb (iomem_wstrb),
    .iomem_addr  (iomem_addr),
    .iomem_wdata (iomem_wdata),
    .iomem_ready (iomem_ready),
    .iomem_rdata (iomem_rdata),
    .audio_out   (audio_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // checking and bus tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s got no response within %0d clocks", what, wait_limit);
    $display("ERRORS FOUND");
    $finish;
  endtask

  // one strobe transfer, ready sampled on falling edges
  task automatic bus_access(input int word, input logic [3:0] strb, input logic [31:0] data,
                            output logic [31:0] rdata);
    int n;
    logic seen;
    seen = 1'b0;
    @(negedge clk);
    iomem_valid = 1'b1;
    iomem_addr = 32'(word) << 2;
    iomem_wstrb = strb;
    iomem_wdata = data;
    for (n = 0; n < wait_limit && !seen; n++) begin
      @(negedge clk);
      seen = iomem_ready;
    end
    rdata = iomem_rdata;
    iomem_valid = 1'b0;
    iomem_wstrb = 4'h0;
    if (!seen) begin
      stop_on_timeout("iomem transfer");
    end
  endtask

  task automatic bus_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] unused;
    bus_access(word, strb, data, unused);
  endtask

  task automatic bus_read(input int word, output logic [31:0] data);
    bus_access(word, 4'h0, 32'h0, data);
  endtask

  task automatic set_voice(input int v, input logic [23:0] f, input logic [11:0] pw,
                           input logic [31:0] wv, input logic g);
    bus_write(4 * v + 0, {8'h00, f}, 4'hf);
    bus_write(4 * v + 1, {20'h0, pw}, 4'hf);
    bus_write(4 * v + 2, wv, 4'hf);
    bus_write(4 * v + 3, {31'h0, g}, 4'hf);
    cfg_wave[v] = wv;
    cfg_pw[v] = pw;
    cfg_gate[v] = g;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-12s done, %0d mismatches", name, errors - test_start);
    test_start = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  // rounding toward minus infinity, as an arithmetic shift does
  function automatic int floor_div(input int num, input int den);
    if (num >= 0) begin
      return num / den;
    end
    return -((-num + den - 1) / den);
  endfunction

  function automatic int model_sample(input logic [31:0] wv, input logic g,
                                      input logic [23:0] acc, input logic [22:0] lfsr,
                                      input logic ring, input logic [11:0] pw);
    logic [11:0] u;
    logic [11:0] tri_w;
    logic [11:0] noise_w;
    logic inv;
    int level;
    u = 12'hfff;
    inv = wv[audio_pkg::ring_en] ? ring : acc[23];
    tri_w = inv ? ~acc[22:11] : acc[22:11];
    noise_w = {lfsr[22], lfsr[20], lfsr[16], lfsr[13], lfsr[11], lfsr[7], lfsr[4], lfsr[2],
               4'h0};
    if (wv[audio_pkg::wave_tri]) u = u & tri_w;
    if (wv[audio_pkg::wave_saw]) u = u & acc[23:12];
    if (wv[audio_pkg::wave_pulse]) u = u & ((acc[23:12] <= pw) ? 12'hfff : 12'h000);
    if (wv[audio_pkg::wave_noise]) u = u & noise_w;
    if (!wv[audio_pkg::voice_en]) begin
      return 0;
    end
    // offset binary around mid scale
    level = int'(u) - 2048;
    return g ? floor_div(level * 255, 256) : 0;
  endfunction

  // phase zero, seed lfsr and low neighbour msb for every voice
  task automatic check_density(input string name);
    int ones;
    int sum;
    int exp_ones;
    sum = 0;
    for (int v = 0; v < 3; v++) begin
      sum += model_sample(cfg_wave[v], cfg_gate[v], 24'h0, audio_pkg::lfsr_seed, 1'b0,
                          cfg_pw[v]);
    end
    exp_ones = floor_div(sum, 2) + 8192;
    repeat (settle_clks) @(negedge clk);
    ones = 0;
    repeat (count_len) begin
      @(negedge clk);
      if (audio_out) ones++;
    end
    // first order pdm may land one count either side
    if (ones - exp_ones <= 1 && exp_ones - ones <= 1) begin
      exp_ones = ones;
    end
    check_value($sformatf("audio_out ones (%s)", name), ones, exp_ones);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] wv;
    logic [3:0]  strb;
    logic [2:0]  mask;
    logic        seen_hi;
    logic        seen_lo;
    int          word;
    int          sel;
    int          n;
    iomem_valid = 1'b0;
    iomem_wstrb = 4'h0;
    iomem_addr = 32'h0;
    iomem_wdata = 32'h0;
    errors = 0;
    checks = 0;
    tests = 0;
    test_start = 0;
    data = $urandom(32'he81f);
    for (n = 0; n < wait_limit && resetn !== 1'b1; n++) @(negedge clk);
    if (resetn !== 1'b1) stop_on_timeout("reset release");

    // registers: reset values, byte strobes, unmapped words
    check_value("iomem_ready after reset", iomem_ready, 32'h0);
    for (word = 0; word < 16; word++) begin
      bus_read(word, rd);
      check_value($sformatf("word %0d after reset", word), rd, 32'h0);
    end
    for (word = 0; word < 12; word++) shadow[word] = 32'h0;
    repeat (40) begin
      word = $urandom_range(0, 11);
      data = $urandom;
      strb = 4'($urandom_range(0, 15));
      bus_write(word, data, strb);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) shadow[word][8*b +: 8] = data[8*b +: 8];
      end
    end
    for (word = 0; word < 12; word++) begin
      bus_read(word, rd);
      check_value($sformatf("word %0d", word), rd, shadow[word]);
    end
    for (word = 12; word < 16; word++) begin
      bus_write(word, $urandom, 4'hf);
      bus_read(word, rd);
      // status keeps only its sync and msb fields
      if (word == 14) rd = rd & ~32'h0000_0707;
      check_value($sformatf("word %0d after write", word), rd, 32'h0);
    end
    end_test("registers");

    // silence, disabled voices with gate on and then enabled voices with gate off
    for (int v = 0; v < 3; v++) set_voice(v, 24'h0, 12'h0, 32'h0, 1'b1);
    check_density("disabled");
    for (int v = 0; v < 3; v++) begin
      wv = ($urandom & 32'h000f_0000) | en_m;
      set_voice(v, 24'($urandom), 12'($urandom), wv, 1'b0);
    end
    check_density("gate off");
    end_test("silence");

    // pulse at full width stays high at any phase
    repeat (3) begin
      mask = 3'($urandom_range(1, 7));
      for (int v = 0; v < 3; v++) begin
        if (mask[v]) set_voice(v, 24'($urandom), 12'hfff, pulse_m | en_m, 1'b1);
        else set_voice(v, 24'h0, 12'h0, 32'h0, 1'b0);
      end
      check_density($sformatf("pulse mask %0d", mask));
    end
    end_test("pulse");

    // test bit parks the sawtooth at zero
    repeat (3) begin
      mask = 3'($urandom_range(0, 7));
      for (int v = 0; v < 3; v++) begin
        wv = test_m | saw_m | (mask[v] ? en_m : 32'h0);
        set_voice(v, 24'($urandom), 12'h0, wv, mask[v]);
      end
      check_density($sformatf("saw mask %0d", mask));
      bus_read(14, rd);
      check_value("status under test", rd, 32'h0);
    end
    end_test("test saw");

    // noise taps read straight from the seed
    repeat (2) begin
      mask = 3'($urandom_range(1, 7));
      for (int v = 0; v < 3; v++) begin
        wv = test_m | noise_m | (mask[v] ? en_m : 32'h0);
        set_voice(v, 24'($urandom), 12'h0, wv, mask[v]);
      end
      check_density($sformatf("noise mask %0d", mask));
    end
    end_test("noise seed");

    // half scale step flips the msb on every tick
    sel = $urandom_range(0, 2);
    for (int v = 0; v < 3; v++) begin
      if (v == sel) set_voice(v, 24'h800000, 12'h0, en_m, 1'b0);
      else set_voice(v, 24'h0, 12'h0, test_m, 1'b0);
    end
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    repeat (64) begin
      bus_read(14, rd);
      if (rd[8 + sel]) seen_hi = 1'b1;
      else seen_lo = 1'b1;
    end
    check_value($sformatf("status msb %0d high seen", sel), seen_hi, 1'b1);
    check_value($sformatf("status msb %0d low seen", sel), seen_lo, 1'b1);
    end_test("oscillation");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/audio_pkg.sv
hdl/audio_regs.sv
hdl/audio_voice.sv
hdl/audio_mixer.sv
hdl/audio_top.sv
tests/tb_clock_gen.sv
tests/audio_tb.sv

// File: Bender.yml
package:
  name: audio_synth

sources:
  - target: rtl
    files:
      - hdl/audio_pkg.sv
      - hdl/audio_regs.sv
      - hdl/audio_voice.sv
      - hdl/audio_mixer.sv
      - hdl/audio_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/audio_tb.sv
